//--- include/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// line geometry, 16-byte lines of four words
`define IC_OFFSET_BITS 4

// 16 sets, works from 2 to 8 bits
`define IC_INDEX_BITS 4

`define IC_TAG_BITS (32 - `IC_OFFSET_BITS - `IC_INDEX_BITS)

// entries per way
`define IC_SETS (1 << `IC_INDEX_BITS)

// below this, fetches bypass the cache
`define UNCACHED_LIMIT 32'h3000_0000

// at or above this, memory accepts wrapping bursts
`define BURST_BASE 32'ha000_0000

`endif

//--- design/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  typedef struct packed {
    logic                    valid;
    logic [`IC_TAG_BITS-1:0] tag;
    logic [3:0][31:0]        data;  // word n at data[n]
  } ic_line_t;

  // pc split, byte offset dropped
  typedef struct packed {
    logic [`IC_TAG_BITS-1:0]   tag;
    logic [`IC_INDEX_BITS-1:0] index;
    logic [1:0]                word;
  } ic_req_t;

  typedef struct packed {
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        arvalid;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
  } axi_r_t;

  typedef enum logic [1:0] {
    REGION_UNCACHED,
    REGION_BURST,
    REGION_SINGLE
  } ic_region_e;

  typedef enum logic [2:0] {
    IDLE,
    PASS,         // uncached single read
    BURST,        // one wrapping burst refill
    SINGLE_WAIT,  // waiting on one beat of a single-read refill
    SINGLE_NEXT   // issue the next single read
  } ic_state_e;

endpackage

`default_nettype wire

//--- design/refill_counter.sv
`timescale 1ns/10ps
`default_nettype none

module refill_counter (
  input  logic       clock,
  input  logic       reset,
  input  logic       start,
  input  logic [1:0] start_offset,
  input  logic       step,
  output logic [1:0] word_offset,
  output logic       last_beat
);

  logic [1:0] base;   // requested word of the refill
  logic [2:0] count;  // beats taken, 4 means done

  always_ff @(posedge clock) begin
    if (reset) begin
      base  <= '0;
      count <= '0;
    end else if (start) begin
      base  <= start_offset;
      count <= '0;
    end else if (step) begin
      count <= count + 3'd1;
    end
  end

  assign word_offset = base + count[1:0];  // wraps mod 4
  assign last_beat   = (count == 3'd3);

  // a fifth beat would overwrite the line out of order
  assert property (@(posedge clock) disable iff (reset)
    step |-> !count[2]);

endmodule

`default_nettype wire

//--- design/icache_way.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_way
  import icache_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`IC_INDEX_BITS-1:0] index,
  input  logic [`IC_TAG_BITS-1:0]   tag,
  input  logic                      we,
  input  ic_line_t                  wline,
  output logic                      hit,
  output ic_line_t                  line
);

  logic [`IC_SETS-1:0]     valid;
  logic [`IC_TAG_BITS-1:0] tags [`IC_SETS];
  logic [3:0][31:0]        data [`IC_SETS];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (we) begin
      valid[index] <= wline.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (we) begin
      tags[index] <= wline.tag;
      data[index] <= wline.data;
    end
  end

  assign line = '{valid: valid[index], tag: tags[index], data: data[index]};

  assign hit = line.valid && (line.tag == tag);

endmodule

`default_nettype wire

//--- design/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [31:0]               pc,
  input  logic                      req_valid,
  output logic                      req_ready,
  output logic [31:0]               inst,
  output logic                      resp_valid,
  output axi_ar_t                   axi_ar,
  input  logic                      arready,
  input  axi_r_t                    axi_r,
  output logic                      rready,
  output logic                      start,
  output logic                      step,
  output logic [1:0]                start_offset,
  input  logic [1:0]                word_offset,
  input  logic                      last_beat,
  output logic [`IC_INDEX_BITS-1:0] index,
  output logic [`IC_TAG_BITS-1:0]   tag,
  input  logic                      hit_0,
  input  logic                      hit_1,
  input  ic_line_t                  line_0,
  input  ic_line_t                  line_1,
  output logic                      we_0,
  output logic                      we_1,
  output ic_line_t                  wline
);

  ic_state_e        state;
  ic_region_e       region;
  ic_req_t          pc_req;
  ic_req_t          req_q;
  ic_req_t          cur;
  logic             accept;
  logic             beat;
  logic             lru;  // victim way for the next fill
  logic [31:0]      ar_addr;
  logic [7:0]       ar_len;
  logic             ar_valid;
  logic [3:0][31:0] fill;

  assign pc_req = ic_req_t'(pc[31:2]);
  // held request drives the ways while a refill is in flight
  assign cur    = req_ready ? pc_req : req_q;
  assign index  = cur.index;
  assign tag    = cur.tag;

  assign accept = req_valid && req_ready;
  assign rready = (state == PASS) || (state == BURST) || (state == SINGLE_WAIT);
  assign beat   = axi_r.rvalid && rready;
  assign step   = beat && (state != PASS);

  always_comb begin
    if (pc < `UNCACHED_LIMIT) begin
      region = REGION_UNCACHED;
    end else if (pc >= `BURST_BASE) begin
      region = REGION_BURST;
    end else begin
      region = REGION_SINGLE;
    end
  end

  assign start        = accept && (region != REGION_UNCACHED) && !(hit_0 || hit_1);
  assign start_offset = pc_req.word;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= IDLE;
      req_ready  <= 1'b1;
      resp_valid <= 1'b0;
      inst       <= '0;
      ar_valid   <= 1'b0;
      we_0       <= 1'b0;
      we_1       <= 1'b0;
      lru        <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      we_0       <= 1'b0;
      we_1       <= 1'b0;
      if (ar_valid && arready) begin
        ar_valid <= 1'b0;
      end
      unique case (state)
        IDLE: begin
          if (we_0 || we_1) begin  // fill written this cycle
            req_ready <= 1'b1;
            lru       <= ~lru;
          end else if (accept) begin
            if (region == REGION_UNCACHED) begin
              state     <= PASS;
              ar_valid  <= 1'b1;
              req_ready <= 1'b0;
            end else if (hit_0 || hit_1) begin
              resp_valid <= 1'b1;
              inst       <= hit_0 ? line_0.data[pc_req.word] : line_1.data[pc_req.word];
              lru        <= hit_0;  // other way ages
            end else begin
              state     <= (region == REGION_BURST) ? BURST : SINGLE_WAIT;
              ar_valid  <= 1'b1;
              req_ready <= 1'b0;
            end
          end
        end
        PASS: begin
          if (beat) begin
            inst       <= axi_r.rdata;
            resp_valid <= 1'b1;
            req_ready  <= 1'b1;
            state      <= IDLE;
          end
        end
        BURST, SINGLE_WAIT: begin
          if (beat) begin
            if (word_offset == req_q.word) begin  // critical word first
              inst       <= axi_r.rdata;
              resp_valid <= 1'b1;
            end
            if (last_beat) begin
              we_0  <= !lru;
              we_1  <= lru;
              state <= IDLE;
            end else if (state == SINGLE_WAIT) begin
              state <= SINGLE_NEXT;
            end
          end
        end
        SINGLE_NEXT: begin
          ar_valid <= 1'b1;
          state    <= SINGLE_WAIT;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q   <= pc_req;
      ar_addr <= {pc[31:2], 2'b00};
      ar_len  <= (region == REGION_BURST) ? 8'd3 : 8'd0;
    end
    if (state == SINGLE_NEXT) begin  // counter already advanced
      ar_addr <= {req_q.tag, req_q.index, word_offset, 2'b00};
    end
    if (step) begin
      fill[word_offset] <= axi_r.rdata;
    end
  end

  assign wline  = '{valid: 1'b1, tag: req_q.tag, data: fill};
  assign axi_ar = '{araddr: ar_addr, arlen: ar_len, arsize: 3'd2,
                    arburst: 2'b10, arvalid: ar_valid};

  assert property (@(posedge clock) disable iff (reset)
    axi_ar.arvalid && !arready |=> axi_ar.arvalid && $stable(axi_ar.araddr));

  assert property (@(posedge clock) disable iff (reset)
    !(we_0 && we_1));

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] pc,
  input  logic        req_valid,
  output logic        req_ready,
  output logic [31:0] inst,
  output logic        resp_valid,
  output axi_ar_t     axi_ar,
  input  logic        arready,
  input  axi_r_t      axi_r,
  output logic        rready
);

  logic                      start;
  logic                      step;
  logic [1:0]                start_offset;
  logic [1:0]                word_offset;
  logic                      last_beat;
  logic [`IC_INDEX_BITS-1:0] index;
  logic [`IC_TAG_BITS-1:0]   tag;
  logic                      hit_0;
  logic                      hit_1;
  logic                      we_0;
  logic                      we_1;
  ic_line_t                  line_0;
  ic_line_t                  line_1;
  ic_line_t                  wline;

  icache_ctrl ctrl_i (.*);

  refill_counter counter_i (.*);

  icache_way way_0 (
    .clock, .reset, .index, .tag,
    .we(we_0), .wline, .hit(hit_0), .line(line_0)
  );

  icache_way way_1 (
    .clock, .reset, .index, .tag,
    .we(we_1), .wline, .hit(hit_1), .line(line_1)
  );

endmodule

`default_nettype wire

//--- testbench/axi_rom_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_rom_model
  import icache_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    stall_en,
  input  axi_ar_t axi_ar,
  output logic    arready,
  output axi_r_t  axi_r,
  input  logic    rready
);

  axi_ar_t ar_log [64];  // every accepted read address, in order
  int      ar_count = 0;

  task automatic next_cycle(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  initial begin
    logic [31:0] addr;
    logic [7:0]  len;
    logic        taken;
    void'($urandom(60123));
    arready = 1'b0;
    axi_r   = '0;
    forever begin
      next_cycle(1);
      if (!reset && axi_ar.arvalid) begin
        next_cycle(stall_en ? $urandom % 4 : 0);
        arready            = 1'b1;
        ar_log[ar_count]   = axi_ar;  // fields are held while arvalid is high
        addr               = axi_ar.araddr;
        len                = axi_ar.arlen;
        next_cycle(1);
        arready  = 1'b0;
        ar_count = ar_count + 1;
        for (int i = 0; i <= len; i++) begin
          next_cycle(stall_en ? $urandom % 4 : 0);
          axi_r = '{rdata: {addr[31:2], 2'b00} ^ 32'h5a5a_0000,
                    rlast: (i == len), rvalid: 1'b1};
          taken = 1'b0;
          while (!taken) begin
            taken = rready;  // registered, stable until the edge
            next_cycle(1);
          end
          axi_r.rvalid = 1'b0;
          addr = {addr[31:4], addr[3:0] + 4'd4};  // wrap inside the line
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int          clock_period = 10;
  localparam int          num_fetches  = 32;
  localparam logic [31:0] set_stride   = 32'h1 << (`IC_OFFSET_BITS + `IC_INDEX_BITS);

  logic        clock, reset, req_valid, req_ready, resp_valid;
  logic        arready, rready, stall_en;
  logic [31:0] pc, inst;
  axi_ar_t     axi_ar;
  axi_r_t      axi_r;
  int          error_count  = 0;
  int          test_count   = 0;
  int          failed_tests = 0;

  icache_top icache_top_i (.*);

  axi_rom_model rom_i (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(num_fetches * 60 * clock_period);
    $display("timeout: the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic axi_ar_t expected_ar(input logic [31:0] addr, input logic [7:0] len);
    return '{araddr: addr, arlen: len, arsize: 3'd2, arburst: 2'b10, arvalid: 1'b1};
  endfunction

  task automatic check_inst(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_burst(input string name, input axi_ar_t got, input axi_ar_t exp);
    if (got.araddr !== exp.araddr || got.arlen !== exp.arlen ||
        got.arsize !== exp.arsize || got.arburst !== exp.arburst) begin
      $write("error at %0t: %s is addr %h len %0d size %0d burst %b",
             $time, name, got.araddr, got.arlen, got.arsize, got.arburst);
      $display(", expected addr %h len %0d size %0d burst %b",
               exp.araddr, exp.arlen, exp.arsize, exp.arburst);
      error_count++;
    end
  endtask

  task automatic next_cycle(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic wait_idle();
    while (!req_ready) next_cycle(1);
  endtask

  task automatic begin_test(output int start_errors, output int mark);
    reset = 1'b1;
    next_cycle(3);
    reset        = 1'b0;
    start_errors = error_count;
    mark         = rom_i.ar_count;
  endtask

  task automatic end_test(input string name, input int start_errors);
    test_count++;
    if (error_count == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - start_errors);
    end
  endtask

  // a hit must answer in the cycle after acceptance
  task automatic fetch(input logic [31:0] addr, input logic is_hit);
    int latency;
    pc        = addr;
    req_valid = 1'b1;
    wait_idle();
    next_cycle(1);  // accepted at this edge
    req_valid = 1'b0;
    latency   = 1;
    while (!resp_valid) begin
      next_cycle(1);
      latency++;
    end
    check_inst("inst", inst, expected_word(addr));
    if (is_hit) begin
      check_count("resp_valid latency", latency, 1);
    end
  endtask

  task automatic test_uncached();
    logic [31:0] addr;
    int          errs;
    int          mark;
    addr = `UNCACHED_LIMIT - 32'h0000_00fc;
    begin_test(errs, mark);
    fetch(addr, 1'b0);
    fetch(addr, 1'b0);
    wait_idle();
    check_count("ar count", rom_i.ar_count - mark, 2);
    check_burst("second ar", rom_i.ar_log[mark + 1], expected_ar(addr, 8'd0));
    end_test("uncached fetch", errs);
  endtask

  task automatic test_burst(input string label);
    logic [31:0] base;
    int          errs;
    int          mark;
    base = `BURST_BASE + 32'h120;
    begin_test(errs, mark);
    fetch(base + 32'h8, 1'b0);  // miss at word 2
    fetch(base, 1'b1);
    fetch(base + 32'h4, 1'b1);
    fetch(base + 32'hc, 1'b1);
    wait_idle();
    check_count("ar count", rom_i.ar_count - mark, 1);
    check_burst("burst ar", rom_i.ar_log[mark], expected_ar(base + 32'h8, 8'd3));
    end_test(label, errs);
  endtask

  task automatic test_single(input string label);
    logic [31:0] base;
    int          errs;
    int          mark;
    base = `UNCACHED_LIMIT + 32'h0200_0230;
    begin_test(errs, mark);
    fetch(base + 32'h4, 1'b0);  // miss at word 1
    for (int w = 0; w < 4; w++) begin
      fetch(base + 4 * w, 1'b1);
    end
    check_count("ar count", rom_i.ar_count - mark, 4);
    for (int k = 0; k < 4; k++) begin
      check_burst("single ar", rom_i.ar_log[mark + k],
                  expected_ar(base + 4 * ((k + 1) % 4), 8'd0));  // words 1 2 3 0
    end
    end_test(label, errs);
  endtask

  task automatic test_lru(input string label);
    logic [31:0] a;
    int          errs;
    int          mark;
    a = `BURST_BASE + 32'h340;
    begin_test(errs, mark);
    fetch(a, 1'b0);
    fetch(a + set_stride, 1'b0);
    fetch(a, 1'b1);  // b becomes the victim
    fetch(a + 2 * set_stride, 1'b0);
    fetch(a, 1'b1);
    wait_idle();
    check_count("ar count before b", rom_i.ar_count - mark, 3);
    fetch(a + set_stride, 1'b0);
    wait_idle();
    check_count("ar count after b", rom_i.ar_count - mark, 4);
    end_test(label, errs);
  endtask

  initial begin
    reset     = 1'b1;
    pc        = '0;
    req_valid = 1'b0;
    stall_en  = 1'b0;
    test_uncached();
    test_burst("burst miss");
    test_single("single-read miss");
    test_lru("lru replacement");
    stall_en = 1'b1;  // random arready and rvalid delays
    test_burst("burst miss with stalls");
    test_single("single-read miss with stalls");
    test_lru("lru replacement with stalls");
    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
design/icache_pkg.sv
design/refill_counter.sv
design/icache_way.sv
design/icache_ctrl.sv
design/icache_top.sv
testbench/axi_rom_model.sv
testbench/icache_tb.sv
